// File: div_unit_config.svh
`ifndef DIV_UNIT_CONFIG_SVH
`define DIV_UNIT_CONFIG_SVH

// Long mode dividend width
`define DIV_DIVIDEND_W 32

// Divisor, quotient and remainder width
`define DIV_DIVISOR_W 16

// Request FIFO entries, power of two
`define DIV_FIFO_DEPTH 4

// Shift-subtract iterations per mode
`define DIV_LONG_STEPS 32
`define DIV_SHORT_STEPS 16

`endif

// File: div_pkg.sv
`default_nettype none

package div_pkg;

    `include "div_unit_config.svh"

    // Full dividend, short mode uses the low half
    typedef logic [`DIV_DIVIDEND_W-1:0] dividend_t;

    // Divisor as issued, short mode uses the low byte
    typedef logic [`DIV_DIVISOR_W-1:0] divisor_t;

    // Results as returned to the caller
    typedef logic [`DIV_DIVISOR_W-1:0] quot_t;
    typedef logic [`DIV_DIVISOR_W-1:0] rem_t;

    // Extra top bit separates full from empty
    typedef logic [$clog2(`DIV_FIFO_DEPTH):0] fifo_ptr_t;

    // Sequencer FSM
    typedef enum logic [2:0] {
        IDLE,
        LAUNCH,
        WAIT_BUSY,
        RUN,
        DONE
    } seq_state_t;

endpackage

`default_nettype wire

// File: div_req_fifo.sv
`default_nettype none

`include "div_unit_config.svh"

module div_req_fifo import div_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            req,
    input  wire dividend_t dividend,
    input  wire divisor_t  divisor,
    input  wire            len,
    input  wire            sign,
    input  wire            pop,
    output dividend_t      head_dividend,
    output divisor_t       head_divisor,
    output logic           head_len,
    output logic           head_sign,
    output logic           empty,
    output logic           full,
    output logic           req_lost
);

    localparam int ADDR_W = $clog2(`DIV_FIFO_DEPTH);

    // Entry storage, one array per field
    dividend_t mem_dividend [`DIV_FIFO_DEPTH];
    divisor_t  mem_divisor  [`DIV_FIFO_DEPTH];
    logic      mem_len      [`DIV_FIFO_DEPTH];
    logic      mem_sign     [`DIV_FIFO_DEPTH];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    logic      do_write;
    logic      do_read;

    // Same address, wrap bits differ when full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // Strobe while full is thrown away
    assign do_write = req && !full;
    assign do_read  = pop && !empty;

    // Head entry seen by the sequencer
    assign head_dividend = mem_dividend[rd_ptr[ADDR_W-1:0]];
    assign head_divisor  = mem_divisor[rd_ptr[ADDR_W-1:0]];
    assign head_len      = mem_len[rd_ptr[ADDR_W-1:0]];
    assign head_sign     = mem_sign[rd_ptr[ADDR_W-1:0]];

    // Pointers and lost-request flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            req_lost <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Sticky until reset
            if (req && full) begin
                req_lost <= 1'b1;
            end
        end
    end

    // Storage write, no reset on payload
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem_dividend[wr_ptr[ADDR_W-1:0]] <= dividend;
            mem_divisor[wr_ptr[ADDR_W-1:0]]  <= divisor;
            mem_len[wr_ptr[ADDR_W-1:0]]      <= len;
            mem_sign[wr_ptr[ADDR_W-1:0]]     <= sign;
        end
    end

endmodule

`default_nettype wire

// File: div_sequencer.sv
`default_nettype none

module div_sequencer import div_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            empty,
    input  wire dividend_t head_dividend,
    input  wire divisor_t  head_divisor,
    input  wire            head_len,
    input  wire            head_sign,
    input  wire            busy,
    input  wire quot_t     core_quot,
    input  wire rem_t      core_rem,
    input  wire            core_v,
    output logic           pop,
    output logic           start,
    output dividend_t      op0,
    output divisor_t       op1,
    output logic           op_len,
    output logic           op_sign,
    output logic           res_valid,
    output quot_t          quot,
    output rem_t           rem,
    output logic           ovf,
    output logic           running
);

    seq_state_t state;
    logic       take_result;

    // Take the head as soon as something is queued
    assign pop = (state == IDLE) && !empty;

    // Single-cycle launch, core looks for the rising edge
    assign start = (state == LAUNCH);

    // Core has dropped busy, results are final
    assign take_result = (state == RUN) && !busy;

    // Result strobe lines up with the captured outputs
    assign res_valid = (state == DONE);
    assign running   = (state != IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            ovf   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (!empty) begin
                        state <= LAUNCH;
                    end
                end
                LAUNCH: begin
                    state <= WAIT_BUSY;
                end
                // Core raises busy one edge after start
                WAIT_BUSY: begin
                    if (busy) begin
                        state <= RUN;
                    end
                end
                // Falling busy ends the division
                RUN: begin
                    if (!busy) begin
                        state <= DONE;
                        ovf   <= core_v;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Operand copy frees the FIFO slot during the run
    always_ff @(posedge clk) begin
        if (pop) begin
            op0     <= head_dividend;
            op1     <= head_divisor;
            op_len  <= head_len;
            op_sign <= head_sign;
        end
        // Held until the next result
        if (take_result) begin
            quot <= core_quot;
            rem  <= core_rem;
        end
    end

endmodule

`default_nettype wire

// File: div_core.sv
`default_nettype none

`include "div_unit_config.svh"

module div_core import div_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire dividend_t op0,
    input  wire divisor_t  op1,
    input  wire            len,
    input  wire            sign,
    input  wire            start,
    output quot_t          quot,
    output rem_t           rem,
    output logic           busy,
    output logic           v
);

    localparam int DVD_W  = `DIV_DIVIDEND_W;
    localparam int DVS_W  = `DIV_DIVISOR_W;
    // Short mode operands are half width
    localparam int SDVD_W = DVD_W / 2;
    localparam int SDVS_W = DVS_W / 2;
    localparam int STEP_W = $clog2(`DIV_LONG_STEPS);

    localparam logic [STEP_W-1:0] STEP_LAST  = STEP_W'(`DIV_LONG_STEPS - 1);
    localparam logic [STEP_W-1:0] STEP_SHORT = STEP_W'(`DIV_LONG_STEPS - `DIV_SHORT_STEPS);

    // Operand signs and magnitudes
    logic      dvd_neg;
    logic      dvs_neg;
    dividend_t dvd_mag;
    divisor_t  dvs_mag;
    dividend_t dvd_aln;
    divisor_t  dvs_eff;

    // Iteration state
    logic              start_l;
    logic              launch;
    logic              last;
    logic [STEP_W-1:0] st;
    logic [DVS_W:0]    part;
    dividend_t         shreg;
    divisor_t          divor;
    dividend_t         fullq;
    logic              neg_res;
    logic              dz;

    // Per-step arithmetic
    logic           larger;
    logic [DVS_W:0] diff;
    logic [DVS_W:0] keep;
    dividend_t      nx_quot;
    rem_t           nx_rem;
    logic           q_ovf;

    assign launch = start && !start_l;
    assign last   = busy && (st == STEP_LAST);

    always_comb begin
        // Sign bit position depends on mode
        dvd_neg = len ? op0[DVD_W-1] : op0[SDVD_W-1];
        dvs_neg = len ? op1[DVS_W-1] : op1[SDVS_W-1];
        dvd_mag = (sign && dvd_neg) ? dividend_t'(-op0) : op0;
        dvs_mag = (sign && dvs_neg) ? divisor_t'(-op1) : op1;
        // Short dividend moves to the upper half
        dvd_aln = len ? dvd_mag : {dvd_mag[SDVD_W-1:0], {SDVD_W{1'b0}}};
        dvs_eff = len ? dvs_mag : {{(DVS_W-SDVS_W){1'b0}}, dvs_mag[SDVS_W-1:0]};
    end

    // Trial subtraction
    assign larger  = (part >= {1'b0, divor});
    assign diff    = part - {1'b0, divor};
    assign keep    = larger ? diff : part;
    assign nx_quot = {fullq[DVD_W-2:0], larger};
    assign nx_rem  = keep[DVS_W-1:0];

    // Magnitude too wide for the mode
    assign q_ovf = len ? (nx_quot[DVD_W-1:DVS_W] != '0) : (nx_quot[SDVD_W-1:SDVS_W] != '0);

    assign quot = fullq[DVS_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_l <= 1'b0;
            busy    <= 1'b0;
            st      <= '0;
            v       <= 1'b0;
        end else begin
            start_l <= start;
            if (launch) begin
                busy <= 1'b1;
                // Both modes finish at STEP_LAST
                st   <= len ? '0 : STEP_SHORT;
                v    <= 1'b0;
            end else if (busy) begin
                st <= st + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                    v    <= dz || q_ovf;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            fullq   <= '0;
            // First dividend bit already in the partial remainder
            part    <= {{DVS_W{1'b0}}, dvd_aln[DVD_W-1]};
            shreg   <= {dvd_aln[DVD_W-2:0], 1'b0};
            divor   <= dvs_eff;
            neg_res <= sign && (dvd_neg ^ dvs_neg);
            dz      <= (dvs_eff == '0);
        end else if (busy) begin
            fullq <= nx_quot;
            part  <= {keep[DVS_W-1:0], shreg[DVD_W-1]};
            shreg <= shreg << 1;
            if (last) begin
                // Mixed signs flip both results
                rem   <= neg_res ? rem_t'(-nx_rem) : nx_rem;
                fullq <= neg_res ? dividend_t'(-nx_quot) : nx_quot;
            end
        end
    end

endmodule

`default_nettype wire

// File: div_unit.sv
`default_nettype none

module div_unit import div_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            req,
    input  wire dividend_t dividend,
    input  wire divisor_t  divisor,
    input  wire            len,
    input  wire            sign,
    output logic           full,
    output logic           req_lost,
    output logic           res_valid,
    output quot_t          quot,
    output rem_t           rem,
    output logic           ovf,
    output logic           idle
);

    // FIFO head
    dividend_t head_dividend;
    divisor_t  head_divisor;
    logic      head_len;
    logic      head_sign;
    logic      empty;
    logic      pop;

    // Sequencer to core
    dividend_t op0;
    divisor_t  op1;
    logic      op_len;
    logic      op_sign;
    logic      start;
    logic      running;

    // Core results
    quot_t core_quot;
    rem_t  core_rem;
    logic  core_v;
    logic  busy;

    // Nothing queued and nothing in flight
    assign idle = empty && !running;

    div_req_fifo i_div_req_fifo (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .dividend     (dividend),
        .divisor      (divisor),
        .len          (len),
        .sign         (sign),
        .pop          (pop),
        .head_dividend(head_dividend),
        .head_divisor (head_divisor),
        .head_len     (head_len),
        .head_sign    (head_sign),
        .empty        (empty),
        .full         (full),
        .req_lost     (req_lost)
    );

    div_sequencer i_div_sequencer (
        .clk          (clk),
        .rst          (rst),
        .empty        (empty),
        .head_dividend(head_dividend),
        .head_divisor (head_divisor),
        .head_len     (head_len),
        .head_sign    (head_sign),
        .busy         (busy),
        .core_quot    (core_quot),
        .core_rem     (core_rem),
        .core_v       (core_v),
        .pop          (pop),
        .start        (start),
        .op0          (op0),
        .op1          (op1),
        .op_len       (op_len),
        .op_sign      (op_sign),
        .res_valid    (res_valid),
        .quot         (quot),
        .rem          (rem),
        .ovf          (ovf),
        .running      (running)
    );

    div_core i_div_core (
        .clk  (clk),
        .rst  (rst),
        .op0  (op0),
        .op1  (op1),
        .len  (op_len),
        .sign (op_sign),
        .start(start),
        .quot (core_quot),
        .rem  (core_rem),
        .busy (busy),
        .v    (core_v)
    );

endmodule

`default_nettype wire

// File: div_unit_tb_vectors.svh
`ifndef DIV_UNIT_TB_VECTORS_SVH
`define DIV_UNIT_TB_VECTORS_SVH

// Columns: dividend, divisor, len, sign, quot, rem, ovf, check
// Overflow rows carry zero results and a cleared check bit

localparam int NUM_VECS = 23;

function automatic logic [83:0] vec_row(input int idx);
    case (idx)
        // Unsigned long
        0:  vec_row = {32'd1000000, 16'd1234, 2'b10, 16'd810, 16'd460, 2'b01};
        1:  vec_row = {32'h0001_2345, 16'h0100, 2'b10, 16'h0123, 16'h0045, 2'b01};
        2:  vec_row = {32'd17, 16'd300, 2'b10, 16'd0, 16'd17, 2'b01};
        3:  vec_row = {32'h0000_beef, 16'd1, 2'b10, 16'hbeef, 16'd0, 2'b01};
        4:  vec_row = {32'hfffe_0001, 16'hffff, 2'b10, 16'hffff, 16'd0, 2'b01};
        // Unsigned short
        5:  vec_row = {32'd200, 16'd7, 2'b00, 16'd28, 16'd4, 2'b01};
        6:  vec_row = {32'd5, 16'd9, 2'b00, 16'd0, 16'd5, 2'b01};
        7:  vec_row = {32'h0000_00ab, 16'd1, 2'b00, 16'h00ab, 16'd0, 2'b01};
        8:  vec_row = {32'd60000, 16'd250, 2'b00, 16'd240, 16'd0, 2'b01};
        // Signed long, all four sign pairs
        9:  vec_row = {32'd100, 16'd7, 2'b11, 16'd14, 16'd2, 2'b01};
        10: vec_row = {32'hffff_ff9c, 16'd7, 2'b11, 16'hfff2, 16'hfffe, 2'b01};
        11: vec_row = {32'd100, 16'hfff9, 2'b11, 16'hfff2, 16'hfffe, 2'b01};
        12: vec_row = {32'hffff_ff9c, 16'hfff9, 2'b11, 16'd14, 16'd2, 2'b01};
        // Signed short, sign at bit 15 and bit 7
        13: vec_row = {32'h0000_ffce, 16'd6, 2'b01, 16'hfff8, 16'hfffe, 2'b01};
        14: vec_row = {32'd50, 16'h00fa, 2'b01, 16'hfff8, 16'hfffe, 2'b01};
        15: vec_row = {32'h0000_ffce, 16'h00fa, 2'b01, 16'd8, 16'd2, 2'b01};
        16: vec_row = {32'h0000_8100, 16'h0080, 2'b01, 16'h00fe, 16'd0, 2'b01};
        // Zero divisor and oversized quotient
        17: vec_row = {32'd1234, 16'd0, 2'b10, 16'd0, 16'd0, 2'b10};
        18: vec_row = {32'd55, 16'd0, 2'b00, 16'd0, 16'd0, 2'b10};
        19: vec_row = {32'h0002_0000, 16'd1, 2'b10, 16'd0, 16'd0, 2'b10};
        20: vec_row = {32'd1000, 16'd2, 2'b00, 16'd0, 16'd0, 2'b10};
        21: vec_row = {32'h0000_8000, 16'h0080, 2'b01, 16'd0, 16'd0, 2'b10};
        22: vec_row = {32'hfffe_0000, 16'd1, 2'b11, 16'd0, 16'd0, 2'b10};
        default: vec_row = '0;
    endcase
endfunction

`endif

// File: div_unit_tb.sv
`default_nettype none

`include "div_unit_config.svh"

module div_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    `include "div_unit_tb_vectors.svh"

    localparam int BURST_LEN = `DIV_FIFO_DEPTH + 1;
    // Budget per result plus reset
    localparam int WATCHDOG_CYCLES = (NUM_VECS + BURST_LEN + 2) * 50 + 5;

    logic        clk;
    logic        rst;
    logic        req;
    logic [31:0] dividend;
    logic [15:0] divisor;
    logic        len;
    logic        sign;
    wire         full;
    wire         req_lost;
    wire         res_valid;
    wire  [15:0] quot;
    wire  [15:0] rem;
    wire         ovf;
    wire         idle;

    // Expected results in request order
    logic [15:0] exp_quot [$];
    logic [15:0] exp_rem [$];
    logic        exp_ovf [$];
    logic        exp_chk [$];
    int          exp_id [$];

    int     accepted = 0;
    int     results_seen = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     error_count = 0;
    integer seed = 32'h7b4f;

    div_unit i_div_unit (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .dividend (dividend),
        .divisor  (divisor),
        .len      (len),
        .sign     (sign),
        .full     (full),
        .req_lost (req_lost),
        .res_valid(res_valid),
        .quot     (quot),
        .rem      (rem),
        .ovf      (ovf),
        .idle     (idle)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Truncating division of magnitudes and negation on mixed signs
    task automatic compute_expected(input logic [31:0] dvd, input logic [15:0] dvs,
                                    input logic l, input logic s, output logic [15:0] q,
                                    output logic [15:0] r, output logic o);
        logic        dn;
        logic        sn;
        logic [15:0] neg16;
        logic [7:0]  neg8;
        logic [31:0] dm;
        logic [31:0] sm;
        logic [31:0] qm;
        logic [31:0] rm;
        dn = s && (l ? dvd[31] : dvd[15]);
        sn = s && (l ? dvs[15] : dvs[7]);
        neg16 = -dvd[15:0];
        neg8 = -dvs[7:0];
        if (l) begin
            dm = dn ? -dvd : dvd;
            sm = sn ? {16'd0, -dvs} : {16'd0, dvs};
        end else begin
            dm = {16'd0, dn ? neg16 : dvd[15:0]};
            sm = {24'd0, sn ? neg8 : dvs[7:0]};
        end
        q = '0;
        r = '0;
        if (sm == 0) begin
            o = 1'b1;
        end else begin
            qm = dm / sm;
            rm = dm % sm;
            o = l ? (qm > 32'hffff) : (qm > 32'hff);
            q = (dn ^ sn) ? -qm[15:0] : qm[15:0];
            r = (dn ^ sn) ? -rm[15:0] : rm[15:0];
        end
    endtask

    task automatic push_expected(input logic [15:0] q, input logic [15:0] r, input logic o,
                                 input logic chk, input int id);
        exp_quot.push_back(q);
        exp_rem.push_back(r);
        exp_ovf.push_back(o);
        exp_chk.push_back(chk);
        exp_id.push_back(id);
        accepted++;
    endtask

    // Compare each result strobe against the oldest expected entry
    always @(posedge clk) begin : check_results
        logic [15:0] q;
        logic [15:0] r;
        logic        o;
        logic        chk;
        int          id;
        int          bad;
        if (res_valid) begin
            results_seen++;
            assert (exp_id.size() != 0) else begin
                $display("result strobe at %0t arrived with no request outstanding", $time);
                error_count++;
            end
            if (exp_id.size() != 0) begin
                q = exp_quot.pop_front();
                r = exp_rem.pop_front();
                o = exp_ovf.pop_front();
                chk = exp_chk.pop_front();
                id = exp_id.pop_front();
                bad = 0;
                assert (ovf === o) else begin
                    $display("error %0t ovf expected %b got %b", $time, o, ovf);
                    bad++;
                end
                if (chk) begin
                    assert (quot === q) else begin
                        $display("error %0t quot expected %h got %h", $time, q, quot);
                        bad++;
                    end
                    assert (rem === r) else begin
                        $display("error %0t rem expected %h got %h", $time, r, rem);
                        bad++;
                    end
                end
                if (bad == 0) begin
                    pass_count++;
                    $display("test %0d passed", id);
                end else begin
                    fail_count++;
                    $display("test %0d failed", id);
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * 4);
        $display("timeout, results stopped arriving");
        $display("TEST FAIL");
        $finish;
    end

    initial begin : stimulus
        logic [83:0] row;
        logic [15:0] q;
        logic [15:0] r;
        logic        o;
        rst = 1'b1;
        req = 1'b0;
        dividend = '0;
        divisor = '0;
        len = 1'b0;
        sign = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // Quiet state out of reset
        assert (!res_valid && !ovf && !req_lost && !full && idle) else begin
            $display("outputs are not in their reset state before the first request");
            error_count++;
        end
        // Directed table with one request at a time
        for (int i = 0; i < NUM_VECS; i++) begin
            row = vec_row(i);
            push_expected(row[33:18], row[17:2], row[1], row[0], i);
            req <= 1'b1;
            dividend <= row[83:52];
            divisor <= row[51:36];
            len <= row[35];
            sign <= row[34];
            @(posedge clk);
            req <= 1'b0;
            wait (results_seen == accepted);
            @(posedge clk);
        end
        // Head is popped at once so one more request fills the queue
        for (int j = 0; j < BURST_LEN; j++) begin
            req <= 1'b1;
            dividend <= $random(seed);
            divisor <= $random(seed);
            len <= $random(seed);
            sign <= $random(seed);
            @(posedge clk);
            compute_expected(dividend, divisor, len, sign, q, r, o);
            push_expected(q, r, o, !o, NUM_VECS + j);
        end
        // Extra strobe while full must be dropped
        dividend <= 32'd99;
        divisor <= 16'd3;
        @(posedge clk);
        assert (full && results_seen == NUM_VECS) else begin
            $display("queue did not report full before the first burst result");
            error_count++;
        end
        req <= 1'b0;
        wait (results_seen == accepted);
        repeat (2) @(posedge clk);
        assert (req_lost && idle) else begin
            $display("dropped request not flagged or unit not idle after the burst");
            error_count++;
        end
        repeat (60) @(posedge clk);
        assert (results_seen == accepted) else begin
            $display("dropped request still produced a result");
            error_count++;
        end
        $display("passed %0d failed %0d other check failures %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: div_unit.f
+incdir+.
div_pkg.sv
div_req_fifo.sv
div_sequencer.sv
div_core.sv
div_unit.sv
div_unit_tb.sv

// File: Bender.yml
package:
  name: div_unit

sources:
  - include_dirs:
      - .
    files:
      - div_pkg.sv
      - div_req_fifo.sv
      - div_sequencer.sv
      - div_core.sv
      - div_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - div_unit_tb.sv
